// File: rtl/hps_pkg.sv
package hps_pkg;

	//////////////////////////////////////////////////
	// host command set

	// low byte of the first word of a command
	typedef enum logic [7:0] {
		CMD_CFG         = 8'h01,
		CMD_MOUSE       = 8'h04,
		CMD_KBD         = 8'h05,
		CMD_STATUS      = 8'h1E,
		CMD_LED         = 8'h1F,
		CMD_PS2_STAT    = 8'h21,
		CMD_FILE_TX     = 8'h53,
		CMD_FILE_TX_DAT = 8'h54,
		CMD_FILE_INDEX  = 8'h55
	} hps_cmd_e;

	// strobed word bus from the host
	typedef struct packed {
		logic        enable;
		logic        strobe;
		logic [15:0] din;
	} host_bus_t;

	//////////////////////////////////////////////////
	// ps/2 channels

	localparam int N_PS2    = 2;
	localparam int CH_KBD   = 0;
	localparam int CH_MOUSE = 1;

	// fill field sized so a full status fits one 16-bit host word
	localparam int FILL_W = 14;

	typedef struct packed {
		logic       we;
		logic [7:0] data;
	} ps2_wr_t;

	typedef struct packed {
		logic              tx_empty;
		logic              busy;
		logic [FILL_W-1:0] fill;
	} ps2_stat_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

	//////////////////////////////////////////////////
	// readback and download

	typedef enum logic [1:0] {
		RD_NONE,
		RD_LED,
		RD_PS2
	} rd_sel_e;

	typedef struct packed {
		rd_sel_e sel;
		logic    chan;
	} rd_req_t;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

endpackage

// File: rtl/hps_cmd_decoder.sv
module hps_cmd_decoder (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::host_bus_t host,
	output logic [7:0]         cfg,
	output logic [31:0]        status,
	output hps_pkg::ps2_wr_t   wr [hps_pkg::N_PS2],
	output hps_pkg::rd_req_t   rd_req
);

	hps_pkg::hps_cmd_e         cmd;
	logic [3:0]                word_cnt;
	logic                      arg_stb;
	logic [hps_pkg::N_PS2-1:0] push;
	logic [7:0]                push_data;

	// any strobed word after the opcode
	assign arg_stb = host.enable && host.strobe && (word_cnt != 4'd0);

	//////////////////////////////////////////////////
	// command framing

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd      <= hps_pkg::hps_cmd_e'(8'h00);
			word_cnt <= 4'd0;
		end else if (!host.enable) begin
			word_cnt <= 4'd0;
		end else if (host.strobe) begin
			// saturate so long keyboard bursts stay in argument mode
			if (word_cnt != 4'hf)
				word_cnt <= word_cnt + 4'd1;
			if (word_cnt == 4'd0)
				cmd <= hps_pkg::hps_cmd_e'(host.din[7:0]);
		end
	end

	//////////////////////////////////////////////////
	// register writes

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg    <= 8'h00;
			status <= 32'h0;
		end else if (arg_stb) begin
			case (cmd)
				hps_pkg::CMD_CFG: cfg <= host.din[7:0];
				hps_pkg::CMD_STATUS: begin
					if (word_cnt == 4'd1)
						status[15:0] <= host.din;
					else if (word_cnt == 4'd2)
						status[31:16] <= host.din;
				end
				default: ;
			endcase
		end
	end

	// ps/2 byte pushes, one cycle after the strobe
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			push <= '0;
		end else begin
			push <= '0;
			if (arg_stb && cmd == hps_pkg::CMD_KBD)
				push[hps_pkg::CH_KBD] <= 1'b1;
			if (arg_stb && cmd == hps_pkg::CMD_MOUSE)
				push[hps_pkg::CH_MOUSE] <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (arg_stb)
			push_data <= host.din[7:0];
	end

	always_comb begin
		for (int i = 0; i < hps_pkg::N_PS2; i++) begin
			wr[i].we   = push[i];
			wr[i].data = push_data;
		end
	end

	// readback requests go out with the strobe, readback registers them
	always_comb begin
		rd_req.sel  = hps_pkg::RD_NONE;
		rd_req.chan = 1'b0;
		if (arg_stb) begin
			if (cmd == hps_pkg::CMD_LED) begin
				rd_req.sel = hps_pkg::RD_LED;
			end else if (cmd == hps_pkg::CMD_PS2_STAT) begin
				if (word_cnt == 4'd1 || word_cnt == 4'd2) begin
					rd_req.sel  = hps_pkg::RD_PS2;
					rd_req.chan = (word_cnt == 4'd2);
				end
			end
		end
	end

	a_strobe_in_frame: assert property (
		@(posedge clk_sys) disable iff (!rst_n) host.strobe |-> host.enable
	) else $error("host strobe outside an enable frame");

endmodule

// File: rtl/hps_file_loader.sv
module hps_file_loader (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::host_bus_t host,
	output hps_pkg::ioctl_t    ioctl
);

	hps_pkg::hps_cmd_e cmd;
	logic              has_cmd;
	logic [24:0]       addr;

	// own framing, independent of the main decoder
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd     <= hps_pkg::hps_cmd_e'(8'h00);
			has_cmd <= 1'b0;
			addr    <= 25'd0;
			ioctl   <= '0;
		end else begin
			ioctl.wr <= 1'b0;
			if (!host.enable) begin
				has_cmd <= 1'b0;
			end else if (host.strobe) begin
				if (!has_cmd) begin
					cmd     <= hps_pkg::hps_cmd_e'(host.din[7:0]);
					has_cmd <= 1'b1;
				end else begin
					case (cmd)
						hps_pkg::CMD_FILE_INDEX: ioctl.index <= host.din[7:0];

						// nonzero starts a download, zero ends it
						hps_pkg::CMD_FILE_TX: begin
							if (host.din[7:0] != 8'h00) begin
								addr           <= 25'd0;
								ioctl.download <= 1'b1;
							end else begin
								ioctl.addr     <= addr;
								ioctl.download <= 1'b0;
							end
						end

						hps_pkg::CMD_FILE_TX_DAT: begin
							ioctl.addr <= addr;
							ioctl.dout <= host.din[7:0];
							ioctl.wr   <= 1'b1;
							addr       <= addr + 25'd1;
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: rtl/ps2_tx_channel.sv
module ps2_tx_channel #(
	parameter int PS2_DIV   = 2000,
	parameter int FIFO_BITS = 5
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::ps2_wr_t   wr,
	output hps_pkg::ps2_stat_t stat,
	output logic               ps2_clk_out,
	output logic               ps2_dat_out
);

	localparam int DEPTH = 1 << FIFO_BITS;
	localparam int PTR_W = FIFO_BITS + 1;
	localparam int DIV_W = (PS2_DIV > 1) ? $clog2(PS2_DIV) : 1;
	localparam int PAD_W = hps_pkg::FILL_W - PTR_W;

	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [PTR_W-1:0] fill;
	logic             empty;
	logic             full;

	logic [DIV_W-1:0] div_cnt;
	logic             div_hit;
	logic             ps2_phase;
	logic             rise;
	logic             fall;

	hps_pkg::ps2_tx_state_e state;
	logic [2:0]             bit_cnt;
	logic                   armed;
	logic                   start;
	logic [7:0]             tx_byte;
	logic                   parity;

	//////////////////////////////////////////////////
	// byte fifo, extra pointer bit tells full from empty

	assign fill  = wptr - rptr;
	assign empty = (wptr == rptr);
	assign full  = (wptr[FIFO_BITS] != rptr[FIFO_BITS]) &&
		(wptr[FIFO_BITS-1:0] == rptr[FIFO_BITS-1:0]);

	//////////////////////////////////////////////////
	// ps/2 clock divider

	assign div_hit = (div_cnt == DIV_W'(PS2_DIV - 1));
	assign rise    = div_hit && !ps2_phase;
	assign fall    = div_hit && ps2_phase;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt   <= '0;
			ps2_phase <= 1'b0;
		end else if (div_hit) begin
			div_cnt   <= '0;
			ps2_phase <= !ps2_phase;
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	//////////////////////////////////////////////////
	// frame transmitter

	// one idle divided period is needed before each frame
	assign start = rise && (state == hps_pkg::TX_IDLE) && armed && !empty;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wptr        <= '0;
			rptr        <= '0;
			state       <= hps_pkg::TX_IDLE;
			bit_cnt     <= 3'd0;
			armed       <= 1'b0;
			ps2_clk_out <= 1'b1;
			ps2_dat_out <= 1'b1;
		end else begin
			if (wr.we)
				wptr <= wptr + PTR_W'(1);

			if (rise) begin
				ps2_clk_out <= 1'b1;
				case (state)
					hps_pkg::TX_IDLE: begin
						if (start) begin
							armed       <= 1'b0;
							rptr        <= rptr + PTR_W'(1);
							bit_cnt     <= 3'd0;
							// start bit
							ps2_dat_out <= 1'b0;
							state       <= hps_pkg::TX_DATA;
						end else if (!empty) begin
							armed <= 1'b1;
						end
					end
					// lsb first, bit_cnt wraps back to zero after bit 7
					hps_pkg::TX_DATA: begin
						ps2_dat_out <= tx_byte[0];
						bit_cnt     <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= hps_pkg::TX_PARITY;
					end
					hps_pkg::TX_PARITY: begin
						ps2_dat_out <= parity;
						state       <= hps_pkg::TX_STOP;
					end
					// stop bit gets its own low half before going idle
					hps_pkg::TX_STOP: begin
						if (bit_cnt == 3'd0) begin
							ps2_dat_out <= 1'b1;
							bit_cnt     <= 3'd1;
						end else begin
							state <= hps_pkg::TX_IDLE;
						end
					end
					default: state <= hps_pkg::TX_IDLE;
				endcase
			end else if (fall) begin
				ps2_clk_out <= (state == hps_pkg::TX_IDLE);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr.we)
			mem[wptr[FIFO_BITS-1:0]] <= wr.data;
		if (start) begin
			tx_byte <= mem[rptr[FIFO_BITS-1:0]];
			// odd parity over the data byte
			parity  <= ~^mem[rptr[FIFO_BITS-1:0]];
		end else if (rise && state == hps_pkg::TX_DATA) begin
			tx_byte <= {1'b0, tx_byte[7:1]};
		end
	end

	assign stat.tx_empty = empty && (state == hps_pkg::TX_IDLE);
	assign stat.busy     = (state != hps_pkg::TX_IDLE);
	assign stat.fill     = {{PAD_W{1'b0}}, fill};

	a_no_overflow: assert property (
		@(posedge clk_sys) disable iff (!rst_n) wr.we |-> !full
	) else $error("ps/2 fifo pushed while full");

endmodule

// File: rtl/hps_readback.sv
module hps_readback (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               enable,
	input  hps_pkg::rd_req_t   rd_req,
	input  hps_pkg::ps2_stat_t stat [hps_pkg::N_PS2],
	input  logic [2:0]         led_status,
	input  logic [2:0]         led_use,
	output logic [15:0]        io_dout
);

	logic [15:0] led_word;
	logic [15:0] ps2_word;

	// status/use pairs per led, 01 marker above
	assign led_word = {
		8'h00, 2'b01,
		led_status[2], led_use[2],
		led_status[1], led_use[1],
		led_status[0], led_use[0]
	};

	assign ps2_word = {
		stat[rd_req.chan].tx_empty,
		stat[rd_req.chan].busy,
		stat[rd_req.chan].fill
	};

	// word holds until the next request or the end of the frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			io_dout <= 16'h0000;
		end else if (!enable) begin
			io_dout <= 16'h0000;
		end else begin
			case (rd_req.sel)
				hps_pkg::RD_LED: io_dout <= led_word;
				hps_pkg::RD_PS2: io_dout <= ps2_word;
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/hps_io_top.sv
module hps_io_top #(
	parameter int PS2_DIV   = 2000,
	parameter int FIFO_BITS = 5
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::host_bus_t host,
	output logic [15:0]        io_dout,
	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic [31:0]        status,
	output hps_pkg::ioctl_t    ioctl,
	input  logic [2:0]         led_status,
	input  logic [2:0]         led_use,
	output logic               ps2_kbd_clk_out,
	output logic               ps2_kbd_data_out,
	output logic               ps2_mouse_clk_out,
	output logic               ps2_mouse_data_out
);

	logic [7:0]                cfg;
	hps_pkg::ps2_wr_t          wr [hps_pkg::N_PS2];
	hps_pkg::ps2_stat_t        stat [hps_pkg::N_PS2];
	hps_pkg::rd_req_t          rd_req;
	logic [hps_pkg::N_PS2-1:0] ps2_clk;
	logic [hps_pkg::N_PS2-1:0] ps2_dat;

	// cfg bits 2, 3 and 5 belong to the video side
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	hps_cmd_decoder decoder_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.host    (host),
		.cfg     (cfg),
		.status  (status),
		.wr      (wr),
		.rd_req  (rd_req)
	);

	hps_file_loader loader_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.host    (host),
		.ioctl   (ioctl)
	);

	for (genvar i = 0; i < hps_pkg::N_PS2; i++) begin : g_ps2
		ps2_tx_channel #(
			.PS2_DIV   (PS2_DIV),
			.FIFO_BITS (FIFO_BITS)
		) channel_i (
			.clk_sys     (clk_sys),
			.rst_n       (rst_n),
			.wr          (wr[i]),
			.stat        (stat[i]),
			.ps2_clk_out (ps2_clk[i]),
			.ps2_dat_out (ps2_dat[i])
		);
	end

	assign ps2_kbd_clk_out    = ps2_clk[hps_pkg::CH_KBD];
	assign ps2_kbd_data_out   = ps2_dat[hps_pkg::CH_KBD];
	assign ps2_mouse_clk_out  = ps2_clk[hps_pkg::CH_MOUSE];
	assign ps2_mouse_data_out = ps2_dat[hps_pkg::CH_MOUSE];

	hps_readback readback_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.enable     (host.enable),
		.rd_req     (rd_req),
		.stat       (stat),
		.led_status (led_status),
		.led_use    (led_use),
		.io_dout    (io_dout)
	);

endmodule

// File: verification/hps_io_tb.sv
module hps_io_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PS2_DIV   = 4;
	localparam int FIFO_BITS = 3;
	// start wait, 11 bits and the idle gap, in divided periods
	localparam int FRAME_CYCLES = 14 * 2 * PS2_DIV;
	localparam int N_FRAMES     = 6 + 8 + 2;
	localparam int CYCLE_LIMIT  = N_FRAMES * FRAME_CYCLES + 2000;

	logic               clk_sys;
	logic               rst_n;
	hps_pkg::host_bus_t host;
	logic [15:0]        io_dout;
	logic [1:0]         buttons;
	logic               forced_scandoubler;
	logic [31:0]        status;
	hps_pkg::ioctl_t    ioctl;
	logic [2:0]         led_status;
	logic [2:0]         led_use;
	logic               ps2_kbd_clk_out;
	logic               ps2_kbd_data_out;
	logic               ps2_mouse_clk_out;
	logic               ps2_mouse_data_out;

	logic [31:0]     lfsr = 32'hc18b;
	int              cycles = 0;
	logic [7:0]      kbd_exp_q [$];
	logic [7:0]      mouse_exp_q [$];
	logic [8:0]      kbd_got_q [$];
	logic [8:0]      mouse_got_q [$];
	hps_pkg::ioctl_t ioctl_exp_q [$];
	hps_pkg::ioctl_t ioctl_got_q [$];
	logic [10:0]     frame_sr [2];
	int              frame_bits [2];
	int              edges [2];
	logic [1:0]      clk_prev;
	logic [1:0]      dat_prev;

	hps_io_top #(
		.PS2_DIV   (PS2_DIV),
		.FIFO_BITS (FIFO_BITS)
	) dut_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.host               (host),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.status             (status),
		.ioctl              (ioctl),
		.led_status         (led_status),
		.led_use            (led_use),
		.ps2_kbd_clk_out    (ps2_kbd_clk_out),
		.ps2_kbd_data_out   (ps2_kbd_data_out),
		.ps2_mouse_clk_out  (ps2_mouse_clk_out),
		.ps2_mouse_data_out (ps2_mouse_data_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// random data and reference model

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function logic [15:0] draw_bits(int n);
		logic [15:0] r;
		r = 16'h0000;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	function logic [7:0] fresh_byte();
		logic [15:0] r;
		r = draw_bits(8);
		return r[7:0];
	endfunction

	// parity bit that makes the count of ones odd
	function automatic logic odd_parity(logic [7:0] b);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones += b[i];
		return (ones % 2) == 0;
	endfunction

	// each led gives a status/use pair, 01 sits above the pairs
	function automatic logic [15:0] led_reply(logic [2:0] s, logic [2:0] u);
		logic [15:0] r;
		r = 16'h0040;
		for (int i = 0; i < 3; i++) begin
			r[2*i+1] = s[i];
			r[2*i]   = u[i];
		end
		return r;
	endfunction

	function automatic logic [15:0] ps2_status_word(logic te, logic busy, logic [13:0] fill);
		logic [15:0] r;
		r     = 16'(fill);
		r[15] = te;
		r[14] = busy;
		return r;
	endfunction

	//////////////////////////////////////////////////
	// checks

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(logic [7:0] got, logic [7:0] exp, string what);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic expect_bit(logic got, logic exp, string what);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0d ns: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic compare_status(logic [31:0] got, logic [31:0] exp, string what);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic verify_word(logic [15:0] got, logic [15:0] exp, string what);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic match_ioctl(hps_pkg::ioctl_t got, hps_pkg::ioctl_t exp, string what);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	//////////////////////////////////////////////////
	// ps/2 frame monitor

	// a bit is the data held during the low half that a rising clock ends
	task automatic sample_channel(logic ch, logic clk_now, logic dat_now);
		if (!clk_prev[ch] && clk_now) begin
			edges[ch]++;
			frame_sr[ch] = {dat_prev[ch], frame_sr[ch][10:1]};
			frame_bits[ch]++;
			if (frame_bits[ch] == 11) begin
				frame_bits[ch] = 0;
				expect_bit(frame_sr[ch][0], 1'b0, "ps/2 start bit");
				expect_bit(frame_sr[ch][10], 1'b1, "ps/2 stop bit");
				if (ch)
					mouse_got_q.push_back(frame_sr[ch][9:1]);
				else
					kbd_got_q.push_back(frame_sr[ch][9:1]);
			end
		end
		clk_prev[ch] = clk_now;
		dat_prev[ch] = dat_now;
	endtask

	always @(negedge clk_sys) begin
		if (!rst_n) begin
			clk_prev   = 2'b11;
			dat_prev   = 2'b11;
			frame_bits = '{0, 0};
			edges      = '{0, 0};
		end else begin
			sample_channel(1'b0, ps2_kbd_clk_out, ps2_kbd_data_out);
			sample_channel(1'b1, ps2_mouse_clk_out, ps2_mouse_data_out);
			if (ioctl.wr)
				ioctl_got_q.push_back(ioctl);
		end
	end

	// results arrive at the falling edge and are compared at the next rising one
	always @(posedge clk_sys) begin
		logic [8:0]      frame;
		logic [7:0]      exp_b;
		hps_pkg::ioctl_t got_io;
		if (kbd_got_q.size() != 0) begin
			frame = kbd_got_q.pop_front();
			if (kbd_exp_q.size() == 0)
				stop_on_error("keyboard sent a frame that was never pushed");
			exp_b = kbd_exp_q.pop_front();
			check_byte(frame[7:0], exp_b, "keyboard frame data");
			expect_bit(frame[8], odd_parity(exp_b), "keyboard frame parity");
		end
		if (mouse_got_q.size() != 0) begin
			frame = mouse_got_q.pop_front();
			if (mouse_exp_q.size() == 0)
				stop_on_error("mouse sent a frame that was never pushed");
			exp_b = mouse_exp_q.pop_front();
			check_byte(frame[7:0], exp_b, "mouse frame data");
			expect_bit(frame[8], odd_parity(exp_b), "mouse frame parity");
		end
		if (ioctl_got_q.size() != 0) begin
			got_io = ioctl_got_q.pop_front();
			if (ioctl_exp_q.size() == 0)
				stop_on_error("download write pulsed with no data word sent");
			match_ioctl(got_io, ioctl_exp_q.pop_front(), "download write");
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
			stop_on_error("timeout, the run took longer than its cycle limit");
	end

	//////////////////////////////////////////////////
	// host bus driver

	task automatic open_command(hps_pkg::hps_cmd_e op);
		@(posedge clk_sys);
		host.enable <= 1'b1;
		host.strobe <= 1'b1;
		host.din    <= {8'h00, op};
		@(posedge clk_sys);
		host.strobe <= 1'b0;
	endtask

	task automatic send_word(logic [15:0] w);
		@(posedge clk_sys);
		host.strobe <= 1'b1;
		host.din    <= w;
		@(posedge clk_sys);
		host.strobe <= 1'b0;
	endtask

	task automatic read_word(logic [15:0] w, output logic [15:0] rd);
		send_word(w);
		@(negedge clk_sys);
		rd = io_dout;
	endtask

	task automatic close_command();
		@(posedge clk_sys);
		host.enable <= 1'b0;
		host.strobe <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_frames_done();
		while (kbd_exp_q.size() != 0 || mouse_exp_q.size() != 0 ||
			ioctl_exp_q.size() != 0)
			@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		logic [7:0]      b;
		logic [7:0]      idx;
		logic [15:0]     w;
		logic [15:0]     w2;
		logic [15:0]     rd;
		logic [2:0]      ls;
		logic [2:0]      lu;
		hps_pkg::ioctl_t io_exp;

		rst_n      = 1'b0;
		host       = '0;
		led_status = 3'b000;
		led_use    = 3'b000;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		match_ioctl(ioctl, '0, "ioctl in reset");
		compare_status(status, 32'h0, "status in reset");
		expect_bit(ps2_kbd_clk_out, 1'b1, "keyboard clock in reset");
		expect_bit(ps2_mouse_data_out, 1'b1, "mouse data in reset");
		@(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_sys);

		// config byte and status word
		b = fresh_byte();
		open_command(hps_pkg::CMD_CFG);
		send_word({8'h00, b});
		close_command();
		@(negedge clk_sys);
		check_byte({6'b0, buttons}, {6'b0, b[1:0]}, "buttons");
		expect_bit(forced_scandoubler, b[4], "forced_scandoubler");
		w  = draw_bits(16);
		w2 = draw_bits(16);
		open_command(hps_pkg::CMD_STATUS);
		send_word(w);
		send_word(w2);
		close_command();
		@(negedge clk_sys);
		compare_status(status, {w2, w}, "status word");

		// keyboard burst, mouse stays quiet
		open_command(hps_pkg::CMD_KBD);
		repeat (6) begin
			b = fresh_byte();
			kbd_exp_q.push_back(b);
			send_word({8'h00, b});
		end
		close_command();
		wait_frames_done();
		if (edges[1] != 0 || !ps2_mouse_clk_out || !ps2_mouse_data_out)
			stop_on_error("mouse lines moved while only the keyboard had data");

		// interleaved pushes to both devices
		repeat (4) begin
			b = fresh_byte();
			kbd_exp_q.push_back(b);
			open_command(hps_pkg::CMD_KBD);
			send_word({8'h00, b});
			close_command();
			b = fresh_byte();
			mouse_exp_q.push_back(b);
			open_command(hps_pkg::CMD_MOUSE);
			send_word({8'h00, b});
			close_command();
		end
		wait_frames_done();

		// status readback right after a push, then once idle
		b = fresh_byte();
		kbd_exp_q.push_back(b);
		open_command(hps_pkg::CMD_KBD);
		send_word({8'h00, b});
		close_command();
		b = fresh_byte();
		mouse_exp_q.push_back(b);
		open_command(hps_pkg::CMD_MOUSE);
		send_word({8'h00, b});
		close_command();
		open_command(hps_pkg::CMD_PS2_STAT);
		read_word(16'h0000, rd);
		if (!rd[14] && rd[13:0] == 14'd0)
			stop_on_error("keyboard status after a push shows neither fill nor busy");
		read_word(16'h0000, rd);
		if (!rd[14] && rd[13:0] == 14'd0)
			stop_on_error("mouse status after a push shows neither fill nor busy");
		close_command();
		wait_frames_done();
		open_command(hps_pkg::CMD_PS2_STAT);
		read_word(16'h0000, rd);
		verify_word(rd, ps2_status_word(1'b1, 1'b0, 14'd0), "idle keyboard status");
		read_word(16'h0000, rd);
		verify_word(rd, ps2_status_word(1'b1, 1'b0, 14'd0), "idle mouse status");
		close_command();
		@(negedge clk_sys);
		verify_word(io_dout, 16'h0000, "readback outside a command");

		// led readback
		w  = draw_bits(6);
		ls = w[5:3];
		lu = w[2:0];
		@(posedge clk_sys);
		led_status <= ls;
		led_use    <= lu;
		open_command(hps_pkg::CMD_LED);
		read_word(16'h0000, rd);
		close_command();
		verify_word(rd, led_reply(ls, lu), "led readback");

		// file download
		idx = fresh_byte();
		open_command(hps_pkg::CMD_FILE_INDEX);
		send_word({8'h00, idx});
		close_command();
		open_command(hps_pkg::CMD_FILE_TX);
		send_word(16'h00ff);
		close_command();
		open_command(hps_pkg::CMD_FILE_TX_DAT);
		for (int i = 0; i < 10; i++) begin
			b = fresh_byte();
			io_exp.download = 1'b1;
			io_exp.index    = idx;
			io_exp.wr       = 1'b1;
			io_exp.addr     = 25'(i);
			io_exp.dout     = b;
			ioctl_exp_q.push_back(io_exp);
			send_word({8'h00, b});
		end
		close_command();
		wait_frames_done();
		open_command(hps_pkg::CMD_FILE_TX);
		send_word(16'h0000);
		close_command();
		@(negedge clk_sys);
		expect_bit(ioctl.download, 1'b0, "download after stop");

		repeat (4) @(posedge clk_sys);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: tb.f
rtl/hps_pkg.sv
rtl/hps_cmd_decoder.sv
rtl/hps_file_loader.sv
rtl/ps2_tx_channel.sv
rtl/hps_readback.sv
rtl/hps_io_top.sv
verification/hps_io_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --timescale 1ns/1ps --top-module hps_io_tb \
		-f tb.f -o hps_io_sim &&
	./obj_dir/hps_io_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
